// ==== src/config_walker.sv ====
`timescale 1ns/100ps

module config_walker #(
    parameter int UNIT_SHIFT = 14
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  upload_pkg::img_size_t image_size,
    output upload_pkg::ddr_addr_t ddr3_addr,
    output logic                  ddr3_rd,
    input  upload_pkg::byte_t     ddr3_dout,
    input  logic                  ddr3_ready,
    output logic                  busy,
    output upload_pkg::err_t      error,
    output logic                  msx2,
    fill_if.walker                fill,
    table_wr_if.walker            tbl
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAN,
        ST_READ,
        ST_CHECK_HEADER,
        ST_DISPATCH,
        ST_BLOCK,
        ST_FILL,
        ST_SET_LAYOUT
    } state_t;

    state_t                state;
    state_t                next_state;
    upload_pkg::byte_t     rec [upload_pkg::REC_BYTES];
    logic [2:0]            head;
    logic [1:0]            slot, subslot, block, count, offset;
    upload_pkg::ref_t      ref_cnt;
    logic                  ref_add;
    upload_pkg::mapper_t   mapper;
    upload_pkg::ram_addr_t blk_len;
    logic                  step, is_rom, is_mem, blk_go, lay_go;

    assign step    = ddr3_ready && !ddr3_rd && !load;  // DDR3 byte valid, no read pending
    assign is_rom  = rec[2] == upload_pkg::BLOCK_ROM;
    assign is_mem  = is_rom || rec[2] == upload_pkg::BLOCK_RAM;
    assign blk_len = upload_pkg::ram_addr_t'(rec[3]) << UNIT_SHIFT;
    assign blk_go  = step && state == ST_BLOCK && is_mem;
    assign lay_go  = step && state == ST_SET_LAYOUT;
    assign busy    = state != ST_IDLE;

    assign fill.clear   = load;
    assign fill.start   = blk_go;
    assign fill.pattern = is_rom ? upload_pkg::PAT_DDR : upload_pkg::pattern_t'(rec[4][2:0]);
    assign fill.length  = blk_len;
    assign fill.base    = fill.addr;
    assign fill.data_ok = ddr3_ready && !ddr3_rd;

    assign tbl.clean      = load;
    assign tbl.look_we    = blk_go;  // Lookup entry at the block start address
    assign tbl.look_ref   = ref_cnt;
    assign tbl.look_addr  = fill.addr;
    assign tbl.look_size  = blk_len;
    assign tbl.look_ro    = is_rom;
    assign tbl.lay_we     = lay_go;
    assign tbl.lay_idx    = {slot, subslot, block};
    assign tbl.lay_ref    = ref_cnt;
    assign tbl.lay_offset = offset;
    assign tbl.lay_ref_en = ref_add;
    assign tbl.lay_mapper = mapper;
    assign tbl.lay_map_en = mapper != upload_pkg::MAPPER_NONE;
    assign tbl.exp_set    = lay_go && subslot != 2'b00;
    assign tbl.exp_slot   = slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            next_state <= ST_IDLE;
            ddr3_addr  <= '0;
            ddr3_rd    <= 1'b0;
            head       <= '0;
            ref_cnt    <= '0;
            error      <= upload_pkg::ERR_NONE;
            msx2       <= 1'b0;
        end else begin
            if (ddr3_ready && ddr3_rd) begin  // Read accepted
                ddr3_addr <= ddr3_addr + 1'b1;
                ddr3_rd   <= 1'b0;
            end
            if (fill.fetch) ddr3_rd <= 1'b1;

            if (load) begin
                state   <= ST_CLEAN;
                error   <= upload_pkg::ERR_NONE;
                msx2    <= 1'b0;
                ref_cnt <= '0;
            end else if (state == ST_FILL) begin
                if (fill.done) state <= ST_SET_LAYOUT;
            end else if (step) begin
                case (state)
                    ST_CLEAN: begin
                        if (!tbl.clean_busy) begin
                            ddr3_addr  <= '0;
                            ddr3_rd    <= 1'b1;  // Prefetch byte 0
                            head       <= '0;
                            next_state <= ST_CHECK_HEADER;
                            state      <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        // ddr3_addr is one past the byte on ddr3_dout
                        if (ddr3_addr > upload_pkg::ddr_addr_t'(image_size)) begin
                            state <= ST_IDLE;
                        end else begin
                            rec[head] <= ddr3_dout;
                            ddr3_rd   <= 1'b1;
                            if (head == 3'(upload_pkg::REC_BYTES - 1)) begin
                                head  <= '0;
                                state <= next_state;
                            end else begin
                                head <= head + 1'b1;
                            end
                        end
                    end
                    ST_CHECK_HEADER: begin
                        if ({rec[0], rec[1], rec[2]} == {"M", "S", "x"}) begin
                            msx2       <= rec[3][0];
                            next_state <= ST_DISPATCH;
                            state      <= ST_READ;
                        end else begin
                            error <= upload_pkg::ERR_BAD_HEADER;
                            state <= ST_IDLE;
                        end
                    end
                    ST_DISPATCH: begin
                        case (upload_pkg::rec_typ_t'(rec[0]))
                            upload_pkg::REC_BLOCK: state <= ST_BLOCK;
                            upload_pkg::REC_END:   state <= ST_IDLE;
                            default: begin
                                error <= upload_pkg::ERR_BAD_RECORD;
                                state <= ST_IDLE;
                            end
                        endcase
                    end
                    ST_BLOCK: begin
                        slot    <= rec[1][7:6];
                        subslot <= rec[1][5:4];
                        block   <= rec[1][3:2];
                        count   <= rec[1][1:0];  // Blocks minus one
                        offset  <= '0;
                        ref_add <= is_mem;
                        mapper  <= upload_pkg::MAPPER_OFFSET;
                        case (upload_pkg::block_typ_t'(rec[2]))
                            upload_pkg::BLOCK_RAM, upload_pkg::BLOCK_ROM: state <= ST_FILL;
                            upload_pkg::BLOCK_MAPPER: begin
                                mapper <= upload_pkg::mapper_t'(rec[3][1:0]);
                                state  <= ST_SET_LAYOUT;
                            end
                            default: begin
                                error <= upload_pkg::ERR_BAD_BLOCK;
                                state <= ST_IDLE;
                            end
                        endcase
                    end
                    ST_SET_LAYOUT: begin
                        block  <= block + 1'b1;
                        offset <= offset + 1'b1;
                        count  <= count - 1'b1;
                        if (count == 2'b00) begin
                            if (ref_add) ref_cnt <= ref_cnt + 1'b1;
                            state <= ST_READ;  // Next record byte already fetched
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== src/download_watch.sv ====
`timescale 1ns/100ps

module download_watch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ioctl_download,
    input  logic [15:0]           ioctl_index,
    input  upload_pkg::img_size_t ioctl_addr,
    input  logic                  reload,
    output upload_pkg::img_size_t image_size,
    output logic                  load
);

    logic download_last;
    logic image_end;

    // Falling edge of the download for the config image
    assign image_end = download_last && !ioctl_download
                       && ioctl_index == upload_pkg::IDX_IMAGE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            download_last <= 1'b0;
            load          <= 1'b0;
            image_size    <= '0;
        end else begin
            download_last <= ioctl_download;
            load          <= reload;  // Reload reuses the last size
            if (image_end) begin
                image_size <= ioctl_addr;
                load       <= 1'b1;
            end
        end
    end

endmodule

// ==== src/layout_table.sv ====
`timescale 1ns/100ps

module layout_table (
    input  logic                    clk,
    input  logic                    rst_n,
    table_wr_if.storage             tbl,
    input  upload_pkg::layout_idx_t layout_sel,
    output upload_pkg::ref_t        layout_ref,
    output logic [1:0]              layout_offset,
    output upload_pkg::mapper_t     layout_mapper,
    input  upload_pkg::ref_t        lookup_sel,
    output upload_pkg::ram_addr_t   lookup_addr,
    output upload_pkg::ram_addr_t   lookup_size,
    output logic                    lookup_ro,
    output logic [3:0]              expander_en
);

    upload_pkg::ref_t        lay_ref   [64];
    logic [1:0]              lay_off   [64];
    upload_pkg::mapper_t     lay_map   [64];
    upload_pkg::ram_addr_t   look_addr [16];
    upload_pkg::ram_addr_t   look_size [16];
    logic                    look_ro   [16];
    upload_pkg::layout_idx_t clean_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tbl.clean_busy <= 1'b0;
            clean_idx      <= '0;
            expander_en    <= '0;
        end else if (tbl.clean) begin
            tbl.clean_busy <= 1'b1;
            clean_idx      <= '0;
            expander_en    <= '0;
        end else begin
            if (tbl.clean_busy) begin  // One entry per cycle, 64 in all
                clean_idx <= clean_idx + 1'b1;
                if (clean_idx == 6'd63) tbl.clean_busy <= 1'b0;
            end
            if (tbl.exp_set) expander_en[tbl.exp_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl.clean_busy) begin
            lay_ref[clean_idx] <= '0;
            lay_off[clean_idx] <= clean_idx[1:0];
            lay_map[clean_idx] <= upload_pkg::MAPPER_NONE;
        end else if (tbl.lay_we) begin
            if (tbl.lay_ref_en) begin
                lay_ref[tbl.lay_idx] <= tbl.lay_ref;
                lay_off[tbl.lay_idx] <= tbl.lay_offset;
            end
            if (tbl.lay_map_en) lay_map[tbl.lay_idx] <= tbl.lay_mapper;
        end
        if (tbl.look_we) begin
            look_addr[tbl.look_ref] <= tbl.look_addr;
            look_size[tbl.look_ref] <= tbl.look_size;
            look_ro[tbl.look_ref]   <= tbl.look_ro;
        end
    end

    assign layout_ref    = lay_ref[layout_sel];
    assign layout_offset = lay_off[layout_sel];
    assign layout_mapper = lay_map[layout_sel];
    assign lookup_addr   = look_addr[lookup_sel];
    assign lookup_size   = look_size[lookup_sel];
    assign lookup_ro     = look_ro[lookup_sel];

endmodule

// ==== src/memory_upload.sv ====
`timescale 1ns/100ps

module memory_upload #(
    parameter int UNIT_SHIFT = 14
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ioctl_download,
    input  logic [15:0]             ioctl_index,
    input  upload_pkg::img_size_t   ioctl_addr,
    input  logic                    reload,
    output upload_pkg::ddr_addr_t   ddr3_addr,
    output logic                    ddr3_rd,
    input  upload_pkg::byte_t       ddr3_dout,
    input  logic                    ddr3_ready,
    output upload_pkg::ram_addr_t   ram_addr,
    output upload_pkg::byte_t       ram_din,
    output logic                    ram_ce,
    input  logic                    sdram_ready,
    output logic                    busy,
    output upload_pkg::err_t        error,
    output logic                    msx2,
    input  upload_pkg::layout_idx_t layout_sel,
    output upload_pkg::ref_t        layout_ref,
    output logic [1:0]              layout_offset,
    output upload_pkg::mapper_t     layout_mapper,
    input  upload_pkg::ref_t        lookup_sel,
    output upload_pkg::ram_addr_t   lookup_addr,
    output upload_pkg::ram_addr_t   lookup_size,
    output logic                    lookup_ro,
    output logic [3:0]              expander_en
);

    upload_pkg::img_size_t image_size;
    logic                  load;

    fill_if     fill ();
    table_wr_if tbl ();

    download_watch i_download_watch (
        .clk            (clk),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .reload         (reload),
        .image_size     (image_size),
        .load           (load)
    );

    config_walker #(.UNIT_SHIFT(UNIT_SHIFT)) i_config_walker (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .image_size (image_size),
        .ddr3_addr  (ddr3_addr),
        .ddr3_rd    (ddr3_rd),
        .ddr3_dout  (ddr3_dout),
        .ddr3_ready (ddr3_ready),
        .busy       (busy),
        .error      (error),
        .msx2       (msx2),
        .fill       (fill.walker),
        .tbl        (tbl.walker)
    );

    ram_filler #(.UNIT_SHIFT(UNIT_SHIFT)) i_ram_filler (
        .clk         (clk),
        .rst_n       (rst_n),
        .f           (fill.filler),
        .ddr3_dout   (ddr3_dout),
        .ram_addr    (ram_addr),
        .ram_din     (ram_din),
        .ram_ce      (ram_ce),
        .sdram_ready (sdram_ready)
    );

    layout_table i_layout_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .tbl           (tbl.storage),
        .layout_sel    (layout_sel),
        .layout_ref    (layout_ref),
        .layout_offset (layout_offset),
        .layout_mapper (layout_mapper),
        .lookup_sel    (lookup_sel),
        .lookup_addr   (lookup_addr),
        .lookup_size   (lookup_size),
        .lookup_ro     (lookup_ro),
        .expander_en   (expander_en)
    );

endmodule

// ==== src/ram_filler.sv ====
`timescale 1ns/100ps

module ram_filler #(
    parameter int UNIT_SHIFT = 14
) (
    input  logic                  clk,
    input  logic                  rst_n,
    fill_if.filler                f,
    input  upload_pkg::byte_t     ddr3_dout,
    output upload_pkg::ram_addr_t ram_addr,
    output upload_pkg::byte_t     ram_din,
    output logic                  ram_ce,
    input  logic                  sdram_ready
);

    logic                  active;
    upload_pkg::ram_addr_t remain;
    upload_pkg::pattern_t  pat;
    upload_pkg::ram_addr_t base;
    logic [8:0]            pos;

    assign pos    = 9'(ram_addr - base);  // Position inside the block
    assign ram_ce = active && remain != '0 && sdram_ready
                    && (pat != upload_pkg::PAT_DDR || f.data_ok);
    assign f.fetch = ram_ce && pat == upload_pkg::PAT_DDR;
    assign f.addr  = ram_addr;

    always_comb begin
        case (pat)
            upload_pkg::PAT_DDR:  ram_din = ddr3_dout;
            upload_pkg::PAT_ZERO: ram_din = 8'h00;
            upload_pkg::PAT_P03:  ram_din = (pos[8] == pos[1]) ? 8'hFF : 8'h00;
            upload_pkg::PAT_P04:  ram_din = (pos[8] != pos[0]) ? 8'hFF : 8'h00;
            upload_pkg::PAT_P05:  ram_din = pos[7] ? 8'hFF : 8'h00;
            default:              ram_din = 8'hFF;  // FF and unknown codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            f.done   <= 1'b0;
            ram_addr <= '0;
        end else begin
            f.done <= 1'b0;
            if (f.clear) begin
                ram_addr <= '0;
            end else if (ram_ce) begin
                ram_addr <= ram_addr + 1'b1;
            end

            if (f.clear) begin
                active <= 1'b0;
            end else if (f.start) begin
                active <= 1'b1;
            end else if (active && remain == '0) begin
                active <= 1'b0;
                f.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (f.start) begin
            remain <= f.length;
            pat    <= f.pattern;
            base   <= f.base;
        end else if (ram_ce) begin
            remain <= remain - 1'b1;
        end
    end

endmodule

// ==== src/upload_if.sv ====
`timescale 1ns/100ps

// Block fill request from the walker to the SDRAM filler
interface fill_if;
    logic                  clear;    // Restart SDRAM address at 0
    logic                  start;
    upload_pkg::pattern_t  pattern;
    upload_pkg::ram_addr_t length;
    upload_pkg::ram_addr_t base;
    logic                  data_ok;  // DDR3 byte valid and no read pending
    logic                  fetch;    // Request next DDR3 byte
    logic                  done;
    upload_pkg::ram_addr_t addr;

    modport walker (output clear, start, pattern, length, base, data_ok,
                    input  fetch, done, addr);
    modport filler (input  clear, start, pattern, length, base, data_ok,
                    output fetch, done, addr);
endinterface

interface table_wr_if;
    logic                    clean;
    logic                    clean_busy;
    logic                    lay_we;
    upload_pkg::layout_idx_t lay_idx;
    upload_pkg::ref_t        lay_ref;
    logic [1:0]              lay_offset;
    logic                    lay_ref_en;
    upload_pkg::mapper_t     lay_mapper;
    logic                    lay_map_en;
    logic                    look_we;
    upload_pkg::ref_t        look_ref;
    upload_pkg::ram_addr_t   look_addr;
    upload_pkg::ram_addr_t   look_size;
    logic                    look_ro;
    logic                    exp_set;
    logic [1:0]              exp_slot;

    modport walker  (output clean, lay_we, lay_idx, lay_ref, lay_offset, lay_ref_en,
                            lay_mapper, lay_map_en, look_we, look_ref, look_addr,
                            look_size, look_ro, exp_set, exp_slot,
                     input  clean_busy);
    modport storage (input  clean, lay_we, lay_idx, lay_ref, lay_offset, lay_ref_en,
                            lay_mapper, lay_map_en, look_we, look_ref, look_addr,
                            look_size, look_ro, exp_set, exp_slot,
                     output clean_busy);
endinterface

// ==== src/upload_pkg.sv ====
package upload_pkg;

    typedef logic [27:0] ddr_addr_t;    // DDR3 byte address
    typedef logic [26:0] ram_addr_t;    // SDRAM byte address
    typedef logic [26:0] img_size_t;    // Download size in bytes
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  ref_t;         // Lookup entry index
    typedef logic [5:0]  layout_idx_t;  // {slot, subslot, block}

    typedef enum logic [1:0] {
        MAPPER_NONE,
        MAPPER_OFFSET,
        MAPPER_LINEAR,
        MAPPER_ASCII8
    } mapper_t;

    typedef enum logic [7:0] {
        BLOCK_RAM    = 8'd1,
        BLOCK_ROM    = 8'd2,
        BLOCK_MAPPER = 8'd3
    } block_typ_t;

    typedef enum logic [7:0] {
        REC_END   = 8'd0,
        REC_BLOCK = 8'd1
    } rec_typ_t;

    typedef enum logic [2:0] {
        PAT_DDR,
        PAT_FF,
        PAT_ZERO,
        PAT_P03,
        PAT_P04,
        PAT_P05
    } pattern_t;

    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_BAD_HEADER,
        ERR_BAD_RECORD,
        ERR_BAD_BLOCK
    } err_t;

    localparam int          REC_BYTES = 6;      // Header and records alike
    localparam logic [15:0] IDX_IMAGE = 16'd1;  // Download index of the config image

endpackage

// ==== tests/ddr3_image_model.sv ====
`timescale 1ns/100ps

module ddr3_image_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  upload_pkg::ddr_addr_t addr,
    input  logic                  rd,
    output upload_pkg::byte_t     dout,
    output logic                  ready
);

    upload_pkg::byte_t     mem [4096];
    upload_pkg::ddr_addr_t rd_addr;
    logic [2:0]            wait_cnt;

    always @(posedge clk) begin
        if (!rst_n) begin
            ready    <= 1'b1;
            dout     <= 8'h00;
            wait_cnt <= '0;
        end else if (rd && ready) begin
            ready    <= 1'b0;
            rd_addr  <= addr;
            wait_cnt <= 3'd1 + 3'(addr[1:0]);  // Latency follows the address
        end else if (!ready) begin
            if (wait_cnt == '0) begin
                dout  <= mem[rd_addr[11:0]];
                ready <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== tests/memory_upload_sva.sv ====
`timescale 1ns/100ps

module memory_upload_sva (
    input logic clk,
    input logic rst_n,
    input logic ram_ce,
    input logic sdram_ready,
    input logic ddr3_rd,
    input logic busy,
    input logic load
);

    a_ce_ready: assert property (@(posedge clk) disable iff (!rst_n) ram_ce |-> sdram_ready)
        else $error("ram_ce high while sdram_ready low");

    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n) ddr3_rd |=> !ddr3_rd)
        else $error("ddr3_rd longer than one cycle");

    a_idle_reset: assert property (@(posedge clk) !rst_n |=> !busy)
        else $error("busy high right after reset");

    a_busy_load: assert property (@(posedge clk) disable iff (!rst_n) $rose(busy) |-> $past(load))
        else $error("busy rose without a load pulse");

endmodule

bind memory_upload memory_upload_sva i_memory_upload_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .ram_ce      (ram_ce),
    .sdram_ready (sdram_ready),
    .ddr3_rd     (ddr3_rd),
    .busy        (busy),
    .load        (load)
);

// ==== tests/tb_memory_upload.sv ====
`timescale 1ns/100ps

module tb_memory_upload;

    localparam int NT = 6;
    localparam int NR = 5;

    logic                    clk, rst_n, ioctl_download, reload, sdram_ready;
    logic                    ddr3_rd, ddr3_ready, ram_ce, busy, msx2, lookup_ro;
    logic [15:0]             ioctl_index;
    upload_pkg::img_size_t   ioctl_addr;
    upload_pkg::ddr_addr_t   ddr3_addr;
    upload_pkg::byte_t       ddr3_dout, ram_din;
    upload_pkg::ram_addr_t   ram_addr, lookup_addr, lookup_size;
    upload_pkg::err_t        error;
    upload_pkg::layout_idx_t layout_sel;
    upload_pkg::ref_t        layout_ref, lookup_sel;
    logic [1:0]              layout_offset;
    upload_pkg::mapper_t     layout_mapper;
    logic [3:0]              expander_en;

    // Stimulus table with one column per test
    logic [23:0]      hdr_id     [NT] = '{"MSX", "MSx", "MSx", "MSx", "MSx", "MSx"};
    logic [7:0]       hdr3       [NT] = '{8'h01, 8'h01, 8'h00, 8'h00, 8'h02, 8'h02};
    int               nrec       [NT] = '{0, 3, 5, 2, 1, 1};
    logic             use_reload [NT] = '{0, 0, 0, 0, 0, 1};
    logic             exp_msx2   [NT] = '{0, 1, 0, 0, 0, 0};
    upload_pkg::err_t exp_err    [NT] = '{upload_pkg::ERR_BAD_HEADER, upload_pkg::ERR_NONE,
                                          upload_pkg::ERR_NONE, upload_pkg::ERR_BAD_RECORD,
                                          upload_pkg::ERR_BAD_BLOCK, upload_pkg::ERR_BAD_BLOCK};
    logic [47:0]      recs [NT][NR];

    logic [7:0]          img [4096];
    logic [7:0]          sdram [2048];
    logic [7:0]          exp_mem [2048];
    int                  img_len, exp_writes, wr_count, nref, errs;
    logic [31:0]         seed = 32'd62985;
    logic [3:0]          e_ref [64];
    logic [1:0]          e_off [64];
    upload_pkg::mapper_t e_map [64];
    int                  l_addr [16], l_size [16];
    logic                l_ro [16];
    logic [3:0]          e_exp;

    memory_upload #(.UNIT_SHIFT(4)) i_memory_upload (.*);

    ddr3_image_model i_ddr3_image_model (.clk(clk), .rst_n(rst_n), .addr(ddr3_addr),
        .rd(ddr3_rd), .dout(ddr3_dout), .ready(ddr3_ready));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(negedge clk) begin
        seed = next_random(seed);
        sdram_ready = seed[18:16] != 3'd0;  // Ready about 7 of 8 cycles
    end

    always @(posedge clk) begin
        if (ram_ce) begin
            if (ram_addr < 2048) sdram[ram_addr] = ram_din;
            wr_count = wr_count + 1;
        end
    end

    function automatic logic [47:0] make_record(input logic [7:0] typ, input logic [1:0] slot,
            input logic [1:0] sub, input logic [1:0] blk, input logic [1:0] cnt,
            input logic [7:0] btyp, input logic [7:0] size, input logic [7:0] pat);
        return {typ, slot, sub, blk, cnt, btyp, size, pat, 8'h00};
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [7:0] pat, input int pos);
        case (pat)
            8'd2: return 8'h00;
            8'd3: return (pos[8] ? pos[1] : !pos[1]) ? 8'hFF : 8'h00;
            8'd4: return (pos[8] ? !pos[0] : pos[0]) ? 8'hFF : 8'h00;
            8'd5: return pos[7] ? 8'hFF : 8'h00;
            default: return 8'hFF;
        endcase
    endfunction

    // Builds the image and the expected SDRAM, layout and lookup contents
    task automatic build_case(input int t);
        logic [7:0] f [6];
        logic [1:0] blk;
        logic [5:0] idx;
        int         p, a, len;
        logic       stop, mem, rom;
        for (int i = 0; i < 64; i++) begin
            e_ref[i] = '0;
            e_off[i] = i[1:0];
            e_map[i] = upload_pkg::MAPPER_NONE;
        end
        {img[0], img[1], img[2]} = hdr_id[t];
        img[3] = hdr3[t];
        img[4] = 8'h00;
        img[5] = 8'h00;
        stop = hdr_id[t] != "MSx";
        p = 6;
        a = 0;
        nref = 0;
        e_exp = '0;
        for (int k = 0; k < nrec[t]; k++) begin
            for (int j = 0; j < 6; j++) begin
                f[j] = recs[t][k][47 - 8 * j -: 8];
                img[p + j] = f[j];
            end
            p += 6;
            rom = f[2] == 8'd2;
            mem = rom || f[2] == 8'd1;
            len = int'(f[3]) * 16;
            if (f[0] != 8'd1 || f[2] < 8'd1 || f[2] > 8'd3) stop = 1'b1;
            if (!stop) begin
                if (mem) begin
                    l_addr[nref] = a;
                    l_size[nref] = len;
                    l_ro[nref] = rom;
                    for (int j = 0; j < len; j++) begin
                        if (rom) img[p + j] = 8'((p + j) * 37 + ((p + j) >> 8));
                        exp_mem[a + j] = rom ? img[p + j] : pattern_byte(f[4], j);
                    end
                    if (rom) p += len;
                    a += len;
                end
                blk = f[1][3:2];
                for (int c = 0; c <= int'(f[1][1:0]); c++) begin
                    idx = {f[1][7:4], blk};
                    if (mem) begin
                        e_ref[idx] = 4'(nref);
                        e_off[idx] = c[1:0];
                        e_map[idx] = upload_pkg::MAPPER_OFFSET;
                    end else if (f[3][1:0] != 2'b00) begin
                        e_map[idx] = upload_pkg::mapper_t'(f[3][1:0]);
                    end
                    blk = blk + 1'b1;
                end
                if (f[1][5:4] != 2'b00) e_exp[f[1][7:6]] = 1'b1;
                if (mem) nref++;
            end
        end
        img_len = p;
        exp_writes = a;
    endtask

    task automatic check_value(input string name, input int expv, input int got);
        if (expv != got) begin
            $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expv, got);
            errs++;
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level) begin
            @(negedge clk);
            n++;
            if (n > 20000) begin
                $display("Timeout: busy did not become %0b within 20000 cycles", level);
                $display("Verification failed");
                $finish;
            end
        end
    endtask

    initial begin
        int fails;
        rst_n = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        reload = 1'b0;
        sdram_ready = 1'b1;
        layout_sel = '0;
        lookup_sel = '0;
        wr_count = 0;
        fails = 0;
        recs[1][0] = make_record(1, 0, 0, 0, 1, 1, 2, upload_pkg::PAT_FF);
        recs[1][1] = make_record(1, 1, 1, 2, 0, 1, 1, upload_pkg::PAT_ZERO);
        recs[1][2] = make_record(0, 0, 0, 0, 0, 0, 0, 0);
        recs[2][0] = make_record(1, 0, 0, 0, 0, 1, 20, upload_pkg::PAT_P03);
        recs[2][1] = make_record(1, 0, 0, 1, 0, 1, 20, upload_pkg::PAT_P04);
        recs[2][2] = make_record(1, 3, 0, 0, 3, 1, 10, upload_pkg::PAT_P05);
        recs[2][3] = make_record(1, 2, 2, 1, 1, 2, 2, 0);
        recs[2][4] = make_record(1, 2, 2, 1, 1, 3, upload_pkg::MAPPER_ASCII8, 0);
        recs[3][0] = make_record(1, 1, 0, 0, 0, 1, 1, upload_pkg::PAT_FF);
        recs[3][1] = make_record(7, 0, 0, 0, 0, 1, 1, 0);
        recs[4][0] = make_record(1, 0, 0, 0, 0, 9, 1, 0);
        recs[5][0] = recs[4][0];
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < NT; t++) begin
            errs = 0;
            build_case(t);
            for (int i = 0; i < 4096; i++) begin
                i_ddr3_image_model.mem[i] = (i < img_len) ? img[i] : 8'(i ^ (i >> 8));
            end
            for (int i = 0; i < 2048; i++) sdram[i] = 8'h00;
            wr_count = 0;
            @(negedge clk);
            if (use_reload[t]) begin
                reload = 1'b1;
                @(negedge clk);
                reload = 1'b0;
            end else begin
                ioctl_index = upload_pkg::IDX_IMAGE;
                ioctl_download = 1'b1;
                repeat (4) @(negedge clk);
                ioctl_addr = upload_pkg::img_size_t'(img_len);
                ioctl_download = 1'b0;
            end
            wait_busy(1'b1);
            wait_busy(1'b0);
            check_value("error", int'(exp_err[t]), int'(error));
            check_value("msx2", int'(exp_msx2[t]), int'(msx2));
            check_value("ram_ce count", exp_writes, wr_count);
            check_value("expander_en", int'(e_exp), int'(expander_en));
            for (int i = 0; i < exp_writes; i++) begin
                check_value($sformatf("sdram[%0d]", i), int'(exp_mem[i]), int'(sdram[i]));
            end
            for (int i = 0; i < 64; i++) begin
                layout_sel = 6'(i);
                @(negedge clk);
                check_value($sformatf("layout_ref[%0d]", i), int'(e_ref[i]), int'(layout_ref));
                check_value($sformatf("layout_offset[%0d]", i), int'(e_off[i]),
                            int'(layout_offset));
                check_value($sformatf("layout_mapper[%0d]", i), int'(e_map[i]),
                            int'(layout_mapper));
            end
            for (int k = 0; k < nref; k++) begin
                lookup_sel = 4'(k);
                @(negedge clk);
                check_value($sformatf("lookup_addr[%0d]", k), l_addr[k], int'(lookup_addr));
                check_value($sformatf("lookup_size[%0d]", k), l_size[k], int'(lookup_size));
                check_value($sformatf("lookup_ro[%0d]", k), int'(l_ro[k]), int'(lookup_ro));
            end
            if (errs != 0) fails++;
            $display("test %0d: %s, %0d errors", t, (errs == 0) ? "ok" : "FAILED", errs);
        end
        $display("tests run %0d, failed %0d", NT, fails);
        if (fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/upload_pkg.sv
src/upload_if.sv
src/download_watch.sv
src/config_walker.sv
src/ram_filler.sv
src/layout_table.sv
src/memory_upload.sv
tests/ddr3_image_model.sv
tests/memory_upload_sva.sv
tests/tb_memory_upload.sv
